// File: memcard.f
+incdir+common
+incdir+dv
common/memcard_csr_pkg.sv
common/memcard_line_pkg.sv
common/memcard_lane_if.sv
source/memcard_clkgen.sv
source/memcard_lane.sv
source/memcard_ctrl.sv
source/memcard.sv
dv/memcard_tb.sv

// File: Makefile
# Verilator build and run of the memory card host interface.
# Any variable can be overridden on the command line, e.g. make LOG=run1.log

VERILATOR ?= verilator
TOP       ?= memcard_tb
RTL_TOP   ?= memcard
FILELIST  ?= memcard.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# The run passes only if the log holds the pass line.
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/memcard_tests.svh
`ifndef MEMCARD_TESTS_SVH
`define MEMCARD_TESTS_SVH

task automatic reset_readback();
	logic [31:0] data;
	logic [31:0] value;
	if (mc_clk !== 1'b0)
		report_mismatch("mc_clk", 32'd0, 32'(mc_clk));
	if (mc_cmd_oe !== 1'b0)
		report_mismatch("mc_cmd_oe", 32'd0, 32'(mc_cmd_oe));
	if (mc_d_oe !== 1'b0)
		report_mismatch("mc_d_oe", 32'd0, 32'(mc_d_oe));
	csr_read(memcard_csr_pkg::REG_DIV, data);
	if (data !== 32'd1023)
		report_mismatch("REG_DIV", 32'd1023, data);
	csr_read(memcard_csr_pkg::REG_ENABLE, data);
	if (data !== 32'd0)
		report_mismatch("REG_ENABLE", 32'd0, data);
	csr_read(memcard_csr_pkg::REG_PENDING, data);
	if (data !== 32'd0)
		report_mismatch("REG_PENDING", 32'd0, data);
	csr_read(memcard_csr_pkg::REG_STARTED, data);
	if (data !== 32'd0)
		report_mismatch("REG_STARTED", 32'd0, data);
	value = rand_bits(11);
	csr_write(memcard_csr_pkg::REG_DIV, value);
	csr_read(memcard_csr_pkg::REG_DIV, data);
	if (data !== value)
		report_mismatch("REG_DIV", value, data);
	// Another block select must read as zero.
	csr_read_addr({`MEMCARD_CSR_BASE ^ 4'h5, 10'd0}, data);
	if (data !== 32'd0)
		report_mismatch("csr_do", 32'd0, data);
endtask

task automatic divider();
	int cycles;
	csr_write(memcard_csr_pkg::REG_DIV, 32'd3);
	wait_mc_edge(~mc_clk, 5000, cycles); // Counter now wraps at the new factor.
	csr_write(memcard_csr_pkg::REG_ENABLE, 32'h1);
	check_clock_still(40); // Transmit enabled with nothing loaded.
	csr_write(memcard_csr_pkg::REG_CMD, rand_bits(8));
	wait_mc_edge(1'b1, 5000, cycles);
	wait_mc_edge(1'b1, 100, cycles);
	if (cycles != 8)
		report_mismatch("mc_clk period", 32'd8, 32'(cycles));
	wait_pending(0, 1'b0, 100);
endtask

// Loads a word and checks each symbol at the card clock rise, MSB first.
task automatic lane_transmit(input logic is_dat, input logic [31:0] word);
	int cycles;
	int width;
	logic [3:0] mask;
	logic [3:0] expected;
	logic [3:0] actual;
	logic oe;
	width = is_dat ? 4 : 1;
	mask = is_dat ? 4'hf : 4'h1;
	csr_write(is_dat ? memcard_csr_pkg::REG_DAT : memcard_csr_pkg::REG_CMD, word);
	for (int i = 7; i >= 0; i--) begin
		wait_mc_edge(1'b1, 100, cycles);
		expected = 4'(word >> (i * width)) & mask;
		actual = is_dat ? mc_d_o : {3'd0, mc_cmd_o};
		oe = is_dat ? mc_d_oe : mc_cmd_oe;
		if (actual !== expected)
			report_mismatch(is_dat ? "mc_d_o" : "mc_cmd_o", 32'(expected), 32'(actual));
		if (oe !== 1'b1)
			report_mismatch(is_dat ? "mc_d_oe" : "mc_cmd_oe", 32'd1, 32'(oe));
	end
	wait_pending(is_dat ? 2 : 0, 1'b0, 50);
	check_clock_still(32); // No ninth card clock.
endtask

task automatic cmd_transmit();
	lane_transmit(1'b0, rand_bits(8));
endtask

task automatic cmd_receive();
	logic [31:0] data;
	logic [31:0] word;
	int cycles;
	csr_write(memcard_csr_pkg::REG_ENABLE, 32'h2);
	word = rand_bits(7); // Bit 7 stays 0 as the start bit.
	card_send(1'b0, word);
	wait_pending(1, 1'b1, 100);
	mc_cmd_i = 1'b1;
	check_clock_still(40); // Held until software collects the word.
	csr_read(memcard_csr_pkg::REG_PENDING, data);
	if (data !== 32'h2)
		report_mismatch("REG_PENDING", 32'h2, data);
	csr_read(memcard_csr_pkg::REG_STARTED, data);
	if (data !== 32'h1)
		report_mismatch("REG_STARTED", 32'h1, data);
	csr_read(memcard_csr_pkg::REG_CMD, data);
	if (data !== word)
		report_mismatch("REG_CMD", word, data);
	csr_write(memcard_csr_pkg::REG_STARTED, 32'h1);
	check_clock_still(16);
	csr_write(memcard_csr_pkg::REG_PENDING, 32'h2);
	wait_mc_edge(~mc_clk, 40, cycles);
	csr_write(memcard_csr_pkg::REG_ENABLE, 32'h0);
endtask

task automatic dat_transmit();
	csr_write(memcard_csr_pkg::REG_ENABLE, 32'h4);
	check_clock_still(16);
	lane_transmit(1'b1, rand_bits(32));
endtask

task automatic dat_receive();
	logic [31:0] data;
	logic [31:0] word;
	csr_write(memcard_csr_pkg::REG_ENABLE, 32'h8);
	word = rand_bits(28); // Top nibble 0 is the start symbol.
	card_send(1'b1, word);
	wait_pending(3, 1'b1, 100);
	mc_d_i = 4'hf;
	csr_read(memcard_csr_pkg::REG_DAT, data);
	if (data !== word)
		report_mismatch("REG_DAT", word, data);
	csr_read(memcard_csr_pkg::REG_STARTED, data);
	if (data !== 32'h2)
		report_mismatch("REG_STARTED", 32'h2, data);
	csr_write(memcard_csr_pkg::REG_STARTED, 32'h2);
	csr_write(memcard_csr_pkg::REG_PENDING, 32'h8);
	csr_read(memcard_csr_pkg::REG_PENDING, data);
	if (data !== 32'h0)
		report_mismatch("REG_PENDING", 32'h0, data);
	csr_read(memcard_csr_pkg::REG_STARTED, data);
	if (data !== 32'h0)
		report_mismatch("REG_STARTED", 32'h0, data);
	csr_write(memcard_csr_pkg::REG_ENABLE, 32'h0);
endtask

`endif

// File: dv/memcard_tb.sv
`include "memcard_cfg.svh"

module memcard_tb;

	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1.

	logic sys_clk;
	logic sys_rst;
	logic [`MEMCARD_CSR_AW-1:0] csr_a;
	logic csr_we;
	logic [31:0] csr_di;
	logic [31:0] csr_do;
	logic mc_cmd_o;
	logic mc_cmd_oe;
	logic mc_cmd_i;
	memcard_line_pkg::dat_line_t mc_d_o;
	logic mc_d_oe;
	memcard_line_pkg::dat_line_t mc_d_i;
	logic mc_clk;

	logic [31:0] lfsr;
	int errors;   // Wrong values.
	int failures; // Timeouts and other failures.

	memcard u_memcard (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.csr_a     (csr_a),
		.csr_we    (csr_we),
		.csr_di    (csr_di),
		.csr_do    (csr_do),
		.mc_cmd_o  (mc_cmd_o),
		.mc_cmd_oe (mc_cmd_oe),
		.mc_cmd_i  (mc_cmd_i),
		.mc_d_o    (mc_d_o),
		.mc_d_oe   (mc_d_oe),
		.mc_d_i    (mc_d_i),
		.mc_clk    (mc_clk)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// Galois LFSR stepped once for every bit taken.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'd0);
		end
		return value;
	endfunction

	function automatic logic [`MEMCARD_CSR_AW-1:0] reg_addr(
		input memcard_csr_pkg::csr_reg_e idx
	);
		return {`MEMCARD_CSR_BASE, 7'd0, idx}; // Block select in the top four bits.
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	task automatic csr_write(input memcard_csr_pkg::csr_reg_e idx, input logic [31:0] data);
		@(posedge sys_clk);
		#1;
		csr_a = reg_addr(idx);
		csr_di = data;
		csr_we = 1'b1;
		@(posedge sys_clk);
		#1;
		csr_we = 1'b0;
	endtask

	// Readback is registered, so csr_do is taken one cycle after the address.
	task automatic csr_read_addr(input logic [`MEMCARD_CSR_AW-1:0] addr,
		output logic [31:0] data);
		@(posedge sys_clk);
		#1;
		csr_a = addr;
		csr_we = 1'b0;
		@(posedge sys_clk);
		#1;
		data = csr_do;
	endtask

	task automatic csr_read(input memcard_csr_pkg::csr_reg_e idx, output logic [31:0] data);
		csr_read_addr(reg_addr(idx), data);
	endtask

	// Returns one time unit after the sys_clk edge on which mc_clk reached level.
	task automatic wait_mc_edge(input logic level, input int limit, output int cycles);
		logic prev;
		logic seen;
		prev = mc_clk;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < limit) begin
			@(posedge sys_clk);
			#1;
			cycles++;
			seen = (prev != level) && (mc_clk == level);
			prev = mc_clk;
		end
		if (!seen)
			report_failure($sformatf("mc_clk did not change to %0d within %0d cycles",
				level, limit));
	endtask

	task automatic check_clock_still(input int span);
		logic start;
		start = mc_clk;
		repeat (span) begin
			@(posedge sys_clk);
			#1;
			if (mc_clk !== start)
				report_mismatch("mc_clk", 32'(start), 32'(mc_clk));
		end
	endtask

	// Polls REG_PENDING until the given bit has the given value.
	task automatic wait_pending(input int bit_idx, input logic value, input int limit);
		logic [31:0] data;
		int tries;
		tries = 0;
		csr_read(memcard_csr_pkg::REG_PENDING, data);
		while (data[bit_idx] !== value && tries < limit) begin
			csr_read(memcard_csr_pkg::REG_PENDING, data);
			tries++;
		end
		if (data[bit_idx] !== value)
			report_failure($sformatf("REG_PENDING bit %0d never became %0d", bit_idx, value));
	endtask

	// Card model for a receive. The line idles high for two card clocks, then
	// each symbol goes out after a falling edge, so it is stable at the next rise.
	task automatic card_send(input logic is_dat, input logic [31:0] word);
		int cycles;
		int width;
		logic [3:0] symbol;
		width = is_dat ? 4 : 1;
		repeat (2) begin
			wait_mc_edge(1'b0, 5000, cycles);
		end
		for (int i = 7; i >= 0; i--) begin
			wait_mc_edge(1'b0, 100, cycles);
			symbol = 4'(word >> (i * width));
			if (is_dat)
				mc_d_i = symbol;
			else
				mc_cmd_i = symbol[0];
		end
	endtask

	`include "memcard_tests.svh"

	initial begin
		lfsr = 32'hb7fd;
		errors = 0;
		failures = 0;
		sys_rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		mc_cmd_i = 1'b1; // Card lines idle high.
		mc_d_i = 4'hf;
		repeat (3) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		reset_readback();
		divider();
		cmd_transmit();
		cmd_receive();
		dat_transmit();
		dat_receive();
		$display("Summary: %0d value errors, %0d other failures", errors, failures);
		if (errors == 0 && failures == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: source/memcard.sv
`include "memcard_cfg.svh"

module memcard (
	input  logic                          sys_clk,
	input  logic                          sys_rst,

	input  logic [`MEMCARD_CSR_AW-1:0]    csr_a,
	input  logic                          csr_we,
	input  logic [31:0]                   csr_di,
	output logic [31:0]                   csr_do,

	output logic                          mc_cmd_o,
	output logic                          mc_cmd_oe,
	input  logic                          mc_cmd_i,
	output memcard_line_pkg::dat_line_t   mc_d_o,
	output logic                          mc_d_oe,
	input  memcard_line_pkg::dat_line_t   mc_d_i,
	output logic                          mc_clk
);

	memcard_csr_pkg::div_factor_t div_factor;
	logic clock_active;
	logic shift_ce;

	memcard_lane_if #(.word_t(memcard_line_pkg::cmd_word_t)) cmd_if ();
	memcard_lane_if #(.word_t(memcard_line_pkg::dat_word_t)) dat_if ();

	memcard_ctrl u_ctrl (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.csr_a        (csr_a),
		.csr_we       (csr_we),
		.csr_di       (csr_di),
		.csr_do       (csr_do),
		.cmd          (cmd_if.ctrl),
		.dat          (dat_if.ctrl),
		.div_factor   (div_factor),
		.clock_active (clock_active)
	);

	memcard_clkgen u_clkgen (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.div_factor   (div_factor),
		.clock_active (clock_active),
		.mc_clk       (mc_clk),
		.shift_ce     (shift_ce)
	);

	// Command line, one bit per card clock.
	memcard_lane #(
		.word_t (memcard_line_pkg::cmd_word_t),
		.WIDTH  (1)
	) u_cmd_lane (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.shift_ce (shift_ce),
		.lane     (cmd_if.lane),
		.line_o   (mc_cmd_o),
		.line_oe  (mc_cmd_oe),
		.line_i   (mc_cmd_i)
	);

	// Data bus, one nibble per card clock.
	memcard_lane #(
		.word_t (memcard_line_pkg::dat_word_t),
		.WIDTH  (4)
	) u_dat_lane (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.shift_ce (shift_ce),
		.lane     (dat_if.lane),
		.line_o   (mc_d_o),
		.line_oe  (mc_d_oe),
		.line_i   (mc_d_i)
	);

endmodule

// File: source/memcard_ctrl.sv
`include "memcard_cfg.svh"

module memcard_ctrl (
	input  logic                         sys_clk,
	input  logic                         sys_rst,
	input  logic [`MEMCARD_CSR_AW-1:0]   csr_a,
	input  logic                         csr_we,
	input  logic [31:0]                  csr_di,
	output logic [31:0]                  csr_do,
	memcard_lane_if.ctrl                 cmd,
	memcard_lane_if.ctrl                 dat,
	output memcard_csr_pkg::div_factor_t div_factor,
	output logic                         clock_active
);

	memcard_csr_pkg::lane_en_t lane_en;
	memcard_csr_pkg::lane_en_t pending;
	memcard_csr_pkg::csr_reg_e reg_idx;
	logic csr_sel;
	logic csr_wr;

	assign csr_sel = (csr_a[`MEMCARD_CSR_AW-1 -: 4] == `MEMCARD_CSR_BASE);
	assign csr_wr = csr_sel & csr_we;
	assign reg_idx = memcard_csr_pkg::csr_reg_e'(csr_a[2:0]);

	// Divider and enable registers.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			div_factor <= `MEMCARD_DIV_RESET;
			lane_en <= '0;
		end else if (csr_wr) begin
			if (reg_idx == memcard_csr_pkg::REG_DIV)
				div_factor <= csr_di[10:0];
			if (reg_idx == memcard_csr_pkg::REG_ENABLE)
				lane_en <= memcard_csr_pkg::lane_en_t'(csr_di[3:0]);
		end
	end

	assign cmd.tx_en = lane_en.cmd_tx;
	assign cmd.rx_en = lane_en.cmd_rx;
	assign dat.tx_en = lane_en.dat_tx;
	assign dat.rx_en = lane_en.dat_rx;

	// Word writes load a transmit.
	assign cmd.load = csr_wr & (reg_idx == memcard_csr_pkg::REG_CMD);
	assign dat.load = csr_wr & (reg_idx == memcard_csr_pkg::REG_DAT);
	assign cmd.load_word = memcard_line_pkg::cmd_word_t'(csr_di[7:0]);
	assign dat.load_word = memcard_line_pkg::dat_word_t'(csr_di);

	// Write one to the rx pending bits to collect a word.
	assign cmd.rx_ack = csr_wr & (reg_idx == memcard_csr_pkg::REG_PENDING) & csr_di[1];
	assign dat.rx_ack = csr_wr & (reg_idx == memcard_csr_pkg::REG_PENDING) & csr_di[3];

	// Write one to clear a started flag.
	assign cmd.started_clr = csr_wr & (reg_idx == memcard_csr_pkg::REG_STARTED) & csr_di[0];
	assign dat.started_clr = csr_wr & (reg_idx == memcard_csr_pkg::REG_STARTED) & csr_di[1];

	always_comb begin
		pending.dat_rx = dat.rx_pending;
		pending.dat_tx = dat.tx_pending;
		pending.cmd_rx = cmd.rx_pending;
		pending.cmd_tx = cmd.tx_pending;
	end

	// Stop the card clock when a transmit has nothing to send
	// or a received word still waits for software.
	assign clock_active = (~lane_en.cmd_tx | pending.cmd_tx)
		& (~lane_en.cmd_rx | ~pending.cmd_rx)
		& (~lane_en.dat_tx | pending.dat_tx)
		& (~lane_en.dat_rx | ~pending.dat_rx);

	// Registered readback, zero outside this block and for spare indices.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else begin
			csr_do <= '0;
			if (csr_sel) begin
				case (reg_idx)
					memcard_csr_pkg::REG_DIV:
						csr_do <= 32'(div_factor);
					memcard_csr_pkg::REG_ENABLE:
						csr_do <= 32'(lane_en);
					memcard_csr_pkg::REG_PENDING:
						csr_do <= 32'(pending);
					memcard_csr_pkg::REG_STARTED:
						csr_do <= {30'd0, dat.started, cmd.started};
					memcard_csr_pkg::REG_CMD:
						csr_do <= 32'(cmd.word);
					memcard_csr_pkg::REG_DAT:
						csr_do <= 32'(dat.word);
					default:
						csr_do <= '0;
				endcase
			end
		end
	end

endmodule

// File: source/memcard_lane.sv
module memcard_lane #(
	parameter type word_t = logic [7:0],
	parameter int  WIDTH  = 1
) (
	input  logic             sys_clk,
	input  logic             sys_rst,
	input  logic             shift_ce,
	memcard_lane_if.lane     lane,
	output logic [WIDTH-1:0] line_o,
	output logic             line_oe,
	input  logic [WIDTH-1:0] line_i
);

	localparam int WORD_W = $bits(word_t);
	localparam int SHIFTS = WORD_W / WIDTH; // Line periods per word.
	localparam int CNT_W  = (SHIFTS > 1) ? $clog2(SHIFTS) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(SHIFTS - 1);

	logic [CNT_W-1:0] bit_count;
	logic start_bit;
	logic rx_go;
	logic shift_en;
	logic last_shift;

	// All line bits low marks the start of a word.
	assign start_bit = (line_i == '0);

	// Receive keeps shifting once the start bit was seen.
	assign rx_go = lane.rx_en & (lane.started | start_bit);
	assign shift_en = shift_ce & (lane.tx_en | rx_go);
	assign last_shift = shift_en & (bit_count == LAST);

	// Shift register, the incoming line enters at the bottom.
	always_ff @(posedge sys_clk) begin
		if (lane.load)
			lane.word <= lane.load_word;
		else if (shift_en)
			lane.word <= word_t'({lane.word[WORD_W-WIDTH-1:0], line_i});
	end

	// Counts shifts within the word, wraps back to zero after the last one.
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			bit_count <= '0;
		else if (lane.load | lane.rx_ack)
			bit_count <= '0;
		else if (shift_en)
			bit_count <= (bit_count == LAST) ? '0 : bit_count + 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			lane.tx_pending <= 1'b0;
			lane.rx_pending <= 1'b0;
		end else begin
			if (lane.load)
				lane.tx_pending <= 1'b1;
			else if (last_shift & lane.tx_en)
				lane.tx_pending <= 1'b0; // Whole word is on the line.
			if (lane.rx_ack)
				lane.rx_pending <= 1'b0;
			else if (last_shift & lane.rx_en)
				lane.rx_pending <= 1'b1; // Word held until software acks.
		end
	end

	// Sticky until software clears it.
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			lane.started <= 1'b0;
		else if (lane.started_clr)
			lane.started <= 1'b0;
		else if (shift_ce & rx_go)
			lane.started <= 1'b1;
	end

	// MSB first on the line.
	assign line_o = lane.word[WORD_W-1 -: WIDTH];
	assign line_oe = lane.tx_en;

endmodule

// File: source/memcard_clkgen.sv
module memcard_clkgen (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  memcard_csr_pkg::div_factor_t div_factor,
	input  logic                      clock_active,
	output logic                      mc_clk,
	output logic                      shift_ce
);

	memcard_csr_pkg::div_factor_t count;
	logic tick;
	logic rise;
	logic rise_d;

	// Half-period counter, wraps at the programmed factor.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			count <= '0;
			tick <= 1'b0;
		end else if (count == div_factor) begin
			count <= '0;
			tick <= 1'b1;
		end else begin
			count <= count + 1'b1;
			tick <= 1'b0;
		end
	end

	// A tick that finds the clock low makes it rise.
	assign rise = tick & clock_active & ~mc_clk;

	// Card clock only moves while the lanes allow it.
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			mc_clk <= 1'b0;
		else if (tick & clock_active)
			mc_clk <= ~mc_clk;
	end

	// Two cycles after the rising edge the lanes shift, once per period.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rise_d <= 1'b0;
			shift_ce <= 1'b0;
		end else begin
			rise_d <= rise;
			shift_ce <= rise_d;
		end
	end

endmodule

// File: common/memcard_lane_if.sv
interface memcard_lane_if #(
	parameter type word_t = logic [7:0]
);

	logic tx_en;        // Lane drives the line.
	logic rx_en;        // Lane listens for a start bit.
	logic load;         // One-cycle pulse, load_word is valid.
	word_t load_word;
	logic rx_ack;       // Software collected the received word.
	logic started_clr;  // Clears the started flag.

	word_t word;        // Shift register contents.
	logic tx_pending;
	logic rx_pending;
	logic started;

	modport ctrl (
		output tx_en,
		output rx_en,
		output load,
		output load_word,
		output rx_ack,
		output started_clr,
		input  word,
		input  tx_pending,
		input  rx_pending,
		input  started
	);

	modport lane (
		input  tx_en,
		input  rx_en,
		input  load,
		input  load_word,
		input  rx_ack,
		input  started_clr,
		output word,
		output tx_pending,
		output rx_pending,
		output started
	);

endinterface

// File: common/memcard_line_pkg.sv
package memcard_line_pkg;

	// Word carried on the one-bit command line.
	typedef logic [7:0] cmd_word_t;

	// Word carried on the four-bit data bus.
	typedef logic [31:0] dat_word_t;

	// Value of the data bus pins in one card clock period.
	typedef logic [3:0] dat_line_t;

endpackage

// File: common/memcard_csr_pkg.sv
package memcard_csr_pkg;

	// Register index, taken from csr_a[2:0].
	typedef enum logic [2:0] {
		REG_DIV     = 3'd0, // Card clock divider factor.
		REG_ENABLE  = 3'd1, // Lane enables.
		REG_PENDING = 3'd2, // Pending flags, rx bits are write-one-to-acknowledge.
		REG_STARTED = 3'd3, // Receive started flags.
		REG_CMD     = 3'd4, // Command word, a write loads a transmit.
		REG_DAT     = 3'd5  // Data word, a write loads a transmit.
	} csr_reg_e;

	// One bit per lane direction.
	// The pending register uses this same layout.
	typedef struct packed {
		logic dat_rx;
		logic dat_tx;
		logic cmd_rx;
		logic cmd_tx;
	} lane_en_t;

	// Half-period count of the card clock, in sys_clk cycles minus one.
	typedef logic [10:0] div_factor_t;

endpackage

// File: common/memcard_cfg.svh
`ifndef MEMCARD_CFG_SVH
`define MEMCARD_CFG_SVH

// Width of the CSR address bus.
`define MEMCARD_CSR_AW 14

// Block select, compared with the top four CSR address bits.
`define MEMCARD_CSR_BASE 4'h0

// Divider half-period count loaded on reset.
// At 1023 the card clock starts slow enough for card identification.
`define MEMCARD_DIV_RESET 11'd1023

`endif
